// File: vlog.f
verilog/dcache_pkg.sv
verilog/dcache_array_if.sv
verilog/dcache_refill_if.sv
verilog/dcache_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_refill.sv
verilog/dcache_top.sv
testbench/tb_mem_responder.sv
testbench/tb_dcache.sv

// File: run.sh
#!/bin/sh
# build the dcache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dcache -Mdir obj_dir -f vlog.f

./obj_dir/Vtb_dcache 2>&1 | tee sim.log

# the log decides, the simulator status alone is not enough
if grep -q "Everything OK" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: testbench/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
  import dcache_pkg::*;
();

  localparam int unsigned NUM_SETS = DEFAULT_NUM_SETS;
  localparam int unsigned NUM_WAYS = DEFAULT_NUM_WAYS;
  localparam int unsigned SEED = 32'h0925_f229;
  localparam int unsigned CLK_PERIOD = 20;
  localparam int unsigned NUM_OPS = 600;
  localparam int unsigned INDEX_W = $clog2(NUM_SETS);
  localparam int unsigned TAG_W = ADDR_WIDTH - INDEX_W - LINE_OFF_WIDTH;
  localparam int unsigned WIDX_W = ADDR_WIDTH - BYTE_OFF_WIDTH;
  // idle gap, lookup, four beats with the longest gaps, done and ack
  localparam int unsigned MISS_CYCLES = 20;
  localparam int unsigned WATCHDOG_CYCLES = 10 + 5 + (NUM_OPS + 4) * MISS_CYCLES;

  typedef struct packed {
    addr_t       addr;
    word_t       data;
    logic        expect_hit;
    int unsigned gnt_cycle;
  } load_t;

  logic  clk_i, rst_ni, req_i, we_i, gnt_o, rvalid_o;
  addr_t addr_i, mem_addr_o;
  word_t wdata_i, rdata_o, mem_wdata_o, mem_rdata_i;
  be_t   be_i, mem_be_o;
  logic  mem_req_o, mem_we_o, mem_rvalid_i;

  // model state
  load_t       loads_q[$];
  word_t       model_mem [2 ** WIDX_W];
  int unsigned cycle = 0;
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned stores_issued = 0;
  int unsigned bus_writes = 0;

  dcache_top #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) dcache_top_i (
    .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .wdata_i, .be_i, .gnt_o, .rvalid_o, .rdata_o,
    .mem_rvalid_i, .mem_rdata_i, .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_be_o
  );

  tb_mem_responder mem_responder_i (
    .clk_i, .rst_ni, .mem_req_i(mem_req_o), .mem_we_i(mem_we_o), .mem_addr_i(mem_addr_o),
    .mem_wdata_i(mem_wdata_o), .mem_be_i(mem_be_o), .mem_rvalid_o(mem_rvalid_i),
    .mem_rdata_o(mem_rdata_i)
  );

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task automatic check_value(input string test, input word_t exp, input word_t act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", test, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  // same rule as the memory model's initial contents
  function automatic word_t fill_word(input logic [WIDX_W-1:0] widx);
    return {widx, 4'h6, ~widx};
  endfunction

  function automatic word_t merge_bytes(input word_t old_data, input word_t new_data, input be_t be);
    word_t res;
    res = old_data;
    for (int b = 0; b < XLEN / 8; b++) begin
      if (be[b]) res[8*b +: 8] = new_data[8*b +: 8];
    end
    return res;
  endfunction

  // four tags over two sets, more lines per set than ways
  function automatic addr_t random_addr();
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    word_sel_t          word;
    tag   = TAG_W'($urandom_range(3, 0) * 37);
    index = INDEX_W'($urandom_range(1, 0) * 5);
    word  = word_sel_t'($urandom_range(LINE_WORDS - 1, 0));
    return {tag, index, word, {BYTE_OFF_WIDTH{1'b0}}};
  endfunction

  // --------------------------------------------------
  // clock, cycle count, watchdog
  // --------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // counted on the falling edge so it is stable at the rising edge
  always @(negedge clk_i) cycle <= cycle + 1;

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("watchdog expired after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  // --------------------------------------------------
  // monitor, load results and refill reads
  // --------------------------------------------------
  always @(posedge clk_i) begin : monitor
    load_t done_load;
    if (rst_ni) begin
      if (rvalid_o && loads_q.size() == 0) begin
        check_true(1'b0, "rvalid_o without an outstanding load");
      end else if (rvalid_o) begin
        done_load = loads_q.pop_front();
        check_value("load data", done_load.data, rdata_o);
        if (done_load.expect_hit) check_value("repeated load latency", done_load.gnt_cycle + 1, cycle);
      end
      if (mem_req_o && mem_we_o) bus_writes++;
      if (mem_req_o && !mem_we_o && loads_q.size() == 0) begin
        check_true(1'b0, "bus read without an outstanding load");
      end else if (mem_req_o && !mem_we_o) begin
        // only the oldest load can miss
        check_true(!loads_q[0].expect_hit, "bus read for a repeated load of a cached line");
        check_value("refill address", word_t'(loads_q[0].addr & ~addr_t'(LINE_WORDS * XLEN / 8 - 1)),
                    word_t'(mem_addr_o));
      end
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin
    load_t       entry;
    addr_t       addr;
    addr_t       prev_addr;
    logic        prev_load;
    logic        is_store;
    int unsigned writes;
    void'($urandom(SEED));
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    for (int i = 0; i < 2 ** WIDX_W; i++) begin
      model_mem[WIDX_W'(i)] = fill_word(WIDX_W'(i));
    end
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    // quiet outputs with no request
    repeat (5) begin
      @(posedge clk_i);
      check_true(!gnt_o && !rvalid_o && !mem_req_o, "DUT output active after reset with no request");
    end
    prev_load = 1'b0;
    prev_addr = '0;
    for (int op = 0; op < NUM_OPS; op++) begin
      @(negedge clk_i);
      is_store = ($urandom_range(2, 0) == 0);
      addr     = random_addr();
      req_i    = 1'b1;
      we_i     = is_store;
      addr_i   = addr;
      wdata_i  = $urandom();
      be_i     = be_t'($urandom_range(15, 1));
      writes   = 0;
      // hold the request until granted, watch the write-through
      do begin
        @(posedge clk_i);
        if (mem_req_o && mem_we_o) begin
          writes++;
          check_true(is_store, "bus write while no store is pending");
          check_value("store address", word_t'(addr), word_t'(mem_addr_o));
          check_value("store data", wdata_i, mem_wdata_o);
          check_value("store byte enables", word_t'(be_i), word_t'(mem_be_o));
          model_mem[addr[ADDR_WIDTH-1:BYTE_OFF_WIDTH]] =
            merge_bytes(model_mem[addr[ADDR_WIDTH-1:BYTE_OFF_WIDTH]], wdata_i, be_i);
        end
      end while (!gnt_o);
      if (is_store) begin
        stores_issued++;
        check_value("store bus writes", 1, writes);
      end else begin
        entry.addr       = addr;
        entry.data       = model_mem[addr[ADDR_WIDTH-1:BYTE_OFF_WIDTH]];
        entry.expect_hit = prev_load &&
                           (addr[ADDR_WIDTH-1:LINE_OFF_WIDTH] == prev_addr[ADDR_WIDTH-1:LINE_OFF_WIDTH]);
        entry.gnt_cycle  = cycle;
        loads_q.push_back(entry);
      end
      prev_load = !is_store;
      prev_addr = addr;
      // an idle cycle now and then
      if ($urandom_range(3, 0) == 0) begin
        @(negedge clk_i);
        req_i = 1'b0;
      end
    end
    @(negedge clk_i);
    req_i = 1'b0;
    while (loads_q.size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    check_value("total bus writes", stores_issued, bus_writes);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_mem_responder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_responder
  import dcache_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  mem_req_i,
  input  wire logic  mem_we_i,
  input  wire addr_t mem_addr_i,
  input  wire word_t mem_wdata_i,
  input  wire be_t   mem_be_i,
  output logic       mem_rvalid_o,
  output word_t      mem_rdata_o
);

  localparam int unsigned WIDX_W = ADDR_WIDTH - BYTE_OFF_WIDTH;
  localparam int unsigned MEM_WORDS = 2 ** WIDX_W;

  // word addressed backing store
  word_t mem [MEM_WORDS];

  initial begin
    logic [WIDX_W-1:0] widx;
    logic [WIDX_W-1:0] rd_idx;
    int unsigned       gap;
    // fill pattern built from the whole word index
    for (int i = 0; i < MEM_WORDS; i++) begin
      widx = WIDX_W'(i);
      mem[widx] = {widx, 4'h6, ~widx};
    end
    mem_rvalid_o = 1'b0;
    mem_rdata_o  = '0;
    forever begin
      @(posedge clk_i);
      if (rst_ni && mem_req_i) begin
        widx = mem_addr_i[ADDR_WIDTH-1:BYTE_OFF_WIDTH];
        if (mem_we_i) begin
          // byte merge, no answer on the bus
          for (int b = 0; b < XLEN / 8; b++) begin
            if (mem_be_i[b]) mem[widx][8*b +: 8] = mem_wdata_i[8*b +: 8];
          end
        end else begin
          // beats in word order from the line base, random gaps of 0 to 2 cycles
          @(negedge clk_i);
          for (int w = 0; w < LINE_WORDS; w++) begin
            gap = $urandom_range(2, 0);
            mem_rvalid_o = 1'b0;
            repeat (gap) @(negedge clk_i);
            rd_idx = widx + WIDX_W'(w);
            mem_rvalid_o = 1'b1;
            mem_rdata_o  = mem[rd_idx];
            @(negedge clk_i);
          end
          mem_rvalid_o = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
  import dcache_pkg::*;
#(
  parameter int unsigned NUM_SETS = DEFAULT_NUM_SETS,
  parameter int unsigned NUM_WAYS = DEFAULT_NUM_WAYS
) (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  // load/store port
  input  wire logic  req_i,
  input  wire logic  we_i,
  input  wire addr_t addr_i,
  input  wire word_t wdata_i,
  input  wire be_t   be_i,
  output logic       gnt_o,
  output logic       rvalid_o,
  output word_t      rdata_o,
  // memory bus
  input  wire logic  mem_rvalid_i,
  input  wire word_t mem_rdata_i,
  output logic       mem_req_o,
  output logic       mem_we_o,
  output addr_t      mem_addr_o,
  output word_t      mem_wdata_o,
  output be_t        mem_be_o
);

  dcache_array_if #(.NUM_SETS(NUM_SETS)) arr_if ();
  dcache_refill_if rfl_if ();

  // ------------------------------------------------
  // controller, array and refill unit
  // ------------------------------------------------
  dcache_ctrl #(
    .NUM_SETS (NUM_SETS)
  ) dcache_ctrl_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .be_i     (be_i),
    .gnt_o    (gnt_o),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o),
    .arr      (arr_if.ctrl),
    .rfl      (rfl_if.ctrl)
  );

  dcache_array #(
    .NUM_SETS (NUM_SETS),
    .NUM_WAYS (NUM_WAYS)
  ) dcache_array_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .arr    (arr_if.array)
  );

  dcache_refill dcache_refill_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_be_o     (mem_be_o),
    .rfl          (rfl_if.refill)
  );

endmodule

`default_nettype wire

// File: verilog/dcache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_refill
  import dcache_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  // memory bus
  input  wire logic        mem_rvalid_i,
  input  wire word_t       mem_rdata_i,
  output logic             mem_req_o,
  output logic             mem_we_o,
  output addr_t            mem_addr_o,
  output word_t            mem_wdata_o,
  output be_t              mem_be_o,
  // controller side
  dcache_refill_if.refill  rfl
);

  // read in flight, waiting for beats
  logic      busy_q;
  word_sel_t beat_q;
  line_t     line_q;
  logic      done_q;
  logic      last_beat;

  assign last_beat = mem_rvalid_i && (beat_q == word_sel_t'(LINE_WORDS - 1));

  // ------------------------------------------------
  // bus request
  // ------------------------------------------------
  // request leaves in the strobe cycle, reads go to the line base
  assign mem_req_o   = rfl.miss_valid;
  assign mem_we_o    = rfl.miss_we;
  assign mem_addr_o  = rfl.miss_we ? rfl.miss_addr :
                       {rfl.miss_addr[ADDR_WIDTH-1:LINE_OFF_WIDTH], {LINE_OFF_WIDTH{1'b0}}};
  assign mem_wdata_o = rfl.miss_wdata;
  assign mem_be_o    = rfl.miss_be;

  // ------------------------------------------------
  // beat counting
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      beat_q <= '0;
      done_q <= 1'b0;
    end else begin
      // write is done the next cycle, read after its last beat
      done_q <= (rfl.miss_valid && rfl.miss_we) || last_beat;
      if (rfl.miss_valid && !rfl.miss_we) begin
        busy_q <= 1'b1;
        beat_q <= '0;
      end else if (mem_rvalid_i) begin
        beat_q <= beat_q + 1'b1;
        if (last_beat) busy_q <= 1'b0;
      end
    end
  end

  // beats arrive in word order, shift in from the top
  always_ff @(posedge clk_i) begin
    if (mem_rvalid_i) line_q <= {mem_rdata_i, line_q[LINE_WORDS-1:1]};
  end

  assign rfl.done        = done_q;
  assign rfl.refill_line = line_q;

  no_miss_when_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rfl.miss_valid |-> !(busy_q || done_q))
    else $error("miss request while refill unit busy");

  no_beat_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i |-> busy_q)
    else $error("read beat without a pending read");

endmodule

`default_nettype wire

// File: verilog/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
  import dcache_pkg::*;
#(
  parameter int unsigned NUM_SETS = DEFAULT_NUM_SETS
) (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  // core port
  input  wire logic      req_i,
  input  wire logic      we_i,
  input  wire addr_t     addr_i,
  input  wire word_t     wdata_i,
  input  wire be_t       be_i,
  output logic           gnt_o,
  output logic           rvalid_o,
  output word_t          rdata_o,
  // array and refill unit
  dcache_array_if.ctrl   arr,
  dcache_refill_if.ctrl  rfl
);

  localparam int unsigned INDEX_WIDTH = $clog2(NUM_SETS);
  localparam int unsigned TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - LINE_OFF_WIDTH;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE_WRITE,
    WAIT_REFILL,
    WAIT_WRITE
  } state_e;

  typedef struct packed {
    addr_t addr;
    logic  we;
    word_t wdata;
    be_t   be;
  } req_t;

  state_e                 state_d, state_q;
  req_t                   req_q;
  // one cycle after done, ends a store or a load miss
  logic                   ack_q;
  word_t                  miss_word_q;

  logic [TAG_WIDTH-1:0]   in_tag, req_tag;
  logic [INDEX_WIDTH-1:0] in_index, req_index;
  word_sel_t              req_word;
  word_t                  hit_word;
  logic                   hit_load;
  logic                   accept;

  // ------------------------------------------------
  // address split
  // ------------------------------------------------
  assign in_tag    = addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign in_index  = addr_i[LINE_OFF_WIDTH +: INDEX_WIDTH];
  assign req_tag   = req_q.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign req_index = req_q.addr[LINE_OFF_WIDTH +: INDEX_WIDTH];
  assign req_word  = req_q.addr[BYTE_OFF_WIDTH +: WORD_SEL_WIDTH];

  assign hit_word  = arr.rdata_line[req_word];

  // load result is back and hit
  assign hit_load  = (state_q == LOOKUP) && !req_q.we && arr.hit;

  // new request in idle, or chained behind a load hit
  // the granted store still holds req_i in its ack cycle
  assign accept = req_i && (((state_q == IDLE) && !(ack_q && req_q.we)) || hit_load);

  // loads are granted at accept, stores when their write is done
  assign gnt_o    = (accept && !we_i) || (ack_q && req_q.we);
  assign rvalid_o = hit_load || (ack_q && !req_q.we);
  assign rdata_o  = hit_load ? hit_word : miss_word_q;

  // ------------------------------------------------
  // FSM
  // ------------------------------------------------
  always_comb begin
    state_d        = state_q;
    // array defaults, lookup with the incoming address
    arr.req        = 1'b0;
    arr.op         = ARR_LOOKUP;
    arr.index      = accept ? in_index : req_index;
    arr.tag        = accept ? in_tag : req_tag;
    arr.word_sel   = req_word;
    arr.wdata      = req_q.wdata;
    arr.be         = req_q.be;
    arr.line       = rfl.refill_line;
    // miss request carries the saved request
    rfl.miss_valid = 1'b0;
    rfl.miss_we    = req_q.we;
    rfl.miss_addr  = req_q.addr;
    rfl.miss_wdata = req_q.wdata;
    rfl.miss_be    = req_q.be;

    if (accept) arr.req = 1'b1;

    case (state_q)
      IDLE: begin
        if (accept) state_d = LOOKUP;
      end
      LOOKUP: begin
        if (req_q.we) begin
          // write-through, every store goes to memory
          rfl.miss_valid = 1'b1;
          state_d = arr.hit ? STORE_WRITE : WAIT_WRITE;
        end else if (arr.hit) begin
          state_d = accept ? LOOKUP : IDLE;
        end else begin
          rfl.miss_valid = 1'b1;
          state_d = WAIT_REFILL;
        end
      end
      STORE_WRITE: begin
        // merge into the hit line while the bus write is out
        arr.req = 1'b1;
        arr.op  = ARR_STORE;
        state_d = rfl.done ? IDLE : WAIT_WRITE;
      end
      WAIT_WRITE: begin
        if (rfl.done) state_d = IDLE;
      end
      WAIT_REFILL: begin
        if (rfl.done) begin
          arr.req = 1'b1;
          arr.op  = ARR_REFILL;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // ------------------------------------------------
  // registers
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= rfl.done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) req_q <= '{addr: addr_i, we: we_i, wdata: wdata_i, be: be_i};
    // requested word out of the finished refill
    if (rfl.done) miss_word_q <= rfl.refill_line[req_word];
  end

  // load data without a hit only comes right after a refill
  store_no_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rvalid_o && !hit_load) |-> ($past(state_q) == WAIT_REFILL))
    else $error("load data returned for a store");

endmodule

`default_nettype wire

// File: verilog/dcache_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_array
  import dcache_pkg::*;
#(
  parameter int unsigned NUM_SETS = DEFAULT_NUM_SETS,
  parameter int unsigned NUM_WAYS = DEFAULT_NUM_WAYS
) (
  input wire logic       clk_i,
  input wire logic       rst_ni,
  dcache_array_if.array  arr
);

  localparam int unsigned INDEX_WIDTH = $clog2(NUM_SETS);
  localparam int unsigned TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - LINE_OFF_WIDTH;
  localparam int unsigned WAY_WIDTH = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  // storage per way
  logic [TAG_WIDTH-1:0]                tag_mem  [NUM_WAYS][NUM_SETS];
  line_t                               data_mem [NUM_WAYS][NUM_SETS];
  logic [NUM_WAYS-1:0][NUM_SETS-1:0]   valid_q;

  // round robin victim pointer per set
  logic [WAY_WIDTH-1:0]                rr_q [NUM_SETS];
  logic [WAY_WIDTH-1:0]                victim;

  logic [NUM_WAYS-1:0]                 hit_way_d, hit_way_q;
  line_t                               line_d, line_q;
  logic                                do_lookup, do_store, do_refill;

  assign do_lookup = arr.req && (arr.op == ARR_LOOKUP);
  assign do_store  = arr.req && (arr.op == ARR_STORE);
  assign do_refill = arr.req && (arr.op == ARR_REFILL);
  assign victim    = rr_q[arr.index];

  // ------------------------------------------------
  // tag compare and way select
  // ------------------------------------------------
  always_comb begin
    hit_way_d = '0;
    line_d    = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_way_d[w] = valid_q[w][arr.index] && (tag_mem[w][arr.index] == arr.tag);
      // or-combine, at most one way is set
      if (hit_way_d[w]) line_d = line_d | data_mem[w][arr.index];
    end
  end

  // hit vector is kept until the next lookup so a store finds its way
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hit_way_q <= '0;
    end else if (do_lookup) begin
      hit_way_q <= hit_way_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_lookup) line_q <= line_d;
  end

  assign arr.hit        = |hit_way_q;
  assign arr.rdata_line = line_q;

  // ------------------------------------------------
  // writes
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      // store merge, byte by byte
      if (do_store && hit_way_q[w]) begin
        for (int b = 0; b < XLEN / 8; b++) begin
          if (arr.be[b]) data_mem[w][arr.index][arr.word_sel][8*b +: 8] <= arr.wdata[8*b +: 8];
        end
      end
      if (do_refill && (victim == WAY_WIDTH'(w))) begin
        tag_mem[w][arr.index]  <= arr.tag;
        data_mem[w][arr.index] <= arr.line;
      end
    end
  end

  // valid bits and victim pointers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      for (int s = 0; s < NUM_SETS; s++) rr_q[s] <= '0;
    end else if (do_refill) begin
      valid_q[victim][arr.index] <= 1'b1;
      if (victim == WAY_WIDTH'(NUM_WAYS - 1)) rr_q[arr.index] <= '0;
      else rr_q[arr.index] <= victim + 1'b1;
    end
  end

  // a line lives in one way only, refills go to missing lines
  one_way_hit: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(hit_way_q))
    else $error("more than one way hit");

endmodule

`default_nettype wire

// File: verilog/dcache_refill_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dcache_refill_if
  import dcache_pkg::*;
();

  // miss or write-through request, single cycle strobe
  logic  miss_valid;
  logic  miss_we;
  addr_t miss_addr;
  word_t miss_wdata;
  be_t   miss_be;

  // completion strobe
  logic  done;
  // assembled line, meaningful with done of a read
  line_t refill_line;

  modport ctrl (output miss_valid, miss_we, miss_addr, miss_wdata, miss_be,
                input done, refill_line);
  modport refill (input miss_valid, miss_we, miss_addr, miss_wdata, miss_be,
                  output done, refill_line);

endinterface

`default_nettype wire

// File: verilog/dcache_array_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dcache_array_if
  import dcache_pkg::*;
#(
  parameter int unsigned NUM_SETS = DEFAULT_NUM_SETS
) ();

  localparam int unsigned INDEX_WIDTH = $clog2(NUM_SETS);
  localparam int unsigned TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - LINE_OFF_WIDTH;

  // request side, one operation per cycle
  logic                   req;
  array_op_e              op;
  logic [INDEX_WIDTH-1:0] index;
  logic [TAG_WIDTH-1:0]   tag;
  // store payload
  word_sel_t              word_sel;
  word_t                  wdata;
  be_t                    be;
  // refill payload
  line_t                  line;
  // lookup result, valid the cycle after the lookup
  logic                   hit;
  line_t                  rdata_line;

  modport ctrl (output req, op, index, tag, word_sel, wdata, be, line, input hit, rdata_line);
  modport array (input req, op, index, tag, word_sel, wdata, be, line, output hit, rdata_line);

endinterface

`default_nettype wire

// File: verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // ------------------------------------------------
  // widths
  // ------------------------------------------------

  // data word and memory bus width
  localparam int unsigned XLEN = 32;
  // byte address width
  localparam int unsigned ADDR_WIDTH = 16;
  // words per cache line, one bus beat each
  localparam int unsigned LINE_WORDS = 4;

  // top level defaults
  localparam int unsigned DEFAULT_NUM_SETS = 16;
  localparam int unsigned DEFAULT_NUM_WAYS = 2;

  // address layout is tag | index | word | byte
  localparam int unsigned BYTE_OFF_WIDTH = $clog2(XLEN / 8);
  localparam int unsigned WORD_SEL_WIDTH = $clog2(LINE_WORDS);
  localparam int unsigned LINE_OFF_WIDTH = BYTE_OFF_WIDTH + WORD_SEL_WIDTH;

  // ------------------------------------------------
  // types
  // ------------------------------------------------

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN/8-1:0] be_t;
  // word 0 sits at the line base
  typedef word_t [LINE_WORDS-1:0] line_t;
  typedef logic [WORD_SEL_WIDTH-1:0] word_sel_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // what the controller asks of the tag/data array
  typedef enum logic [1:0] {
    // tag compare, hit way line comes back one cycle later
    ARR_LOOKUP,
    // byte merge into the way that hit last
    ARR_STORE,
    // whole line into the victim way
    ARR_REFILL
  } array_op_e;

endpackage

`default_nettype wire
